//--- tb.f
hdl/streamer_pkg.sv
hdl/stream_addressgen.sv
hdl/stream_fifo.sv
hdl/tcdm_source.sv
hdl/tcdm_bank.sv
hdl/streamer_source_top.sv
verification/tb_streamer_source.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the streamer source testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  -Wno-fatal \
  --top-module tb_streamer_source \
  -f tb.f \
  -Mdir obj_dir \
  -o sim_tb_streamer_source

# a failing check ends in $fatal, which gives a nonzero exit status
./obj_dir/sim_tb_streamer_source

//--- verification/tb_streamer_source.sv
// Streamer source testbench

`timescale 1ns/100ps

module tb_streamer_source
  import streamer_pkg::*;
();

  localparam int unsigned BANK_WORDS   = 256;
  localparam int unsigned IDX_W        = $clog2(BANK_WORDS);
  localparam int unsigned DONE_TIMEOUT = 2000; // cycles allowed for one job

  logic  clk_i;
  logic  rst_ni;
  logic  clear_i;
  logic  wr_en_i;
  addr_t wr_addr_i;
  word_t wr_data_i;
  logic  start_i;
  addr_t base_addr_i;
  len_t  line_len_i;
  addr_t line_stride_i;
  len_t  line_cnt_i;
  logic  ready_start_o;
  logic  done_o;
  logic  stream_valid_o;
  word_t stream_data_o;
  logic  stream_ready_i;

  word_t       shadow [BANK_WORDS]; // mirror of the bank contents
  string       test_name = "none";
  addr_t       job_base;
  addr_t       job_stride;
  int unsigned job_len = 1;
  int unsigned job_total = 0;
  int unsigned job_first_beat = 0;
  int unsigned beats_seen = 0;  // accepted beats over the whole run

  streamer_source_top #(
    .BANK_WORDS      ( BANK_WORDS ),
    .ADDR_FIFO_DEPTH ( 2          )
  ) streamer_source_top_inst (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .wr_en_i        ( wr_en_i        ),
    .wr_addr_i      ( wr_addr_i      ),
    .wr_data_i      ( wr_data_i      ),
    .start_i        ( start_i        ),
    .base_addr_i    ( base_addr_i    ),
    .line_len_i     ( line_len_i     ),
    .line_stride_i  ( line_stride_i  ),
    .line_cnt_i     ( line_cnt_i     ),
    .ready_start_o  ( ready_start_o  ),
    .done_o         ( done_o         ),
    .stream_valid_o ( stream_valid_o ),
    .stream_data_o  ( stream_data_o  ),
    .stream_ready_i ( stream_ready_i )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_bit(input string what, input logic expected, input logic actual);
    assert (actual === expected) else
      abort_run($sformatf("ERR %s: %s expected %b, actual %b",
                          test_name, what, expected, actual));
  endtask

  // expected word of beat k, line-major walk over the job
  function automatic word_t ref_word(input int unsigned k);
    int unsigned line;
    int unsigned word;
    addr_t       addr;
    line = k / job_len;
    word = k % job_len;
    addr = {job_base[31:2], 2'b00} + addr_t'(line) * {job_stride[31:2], 2'b00}
           + addr_t'(word * 4);
    return shadow[addr[IDX_W+1:2]]; // bank index wraps like the hardware
  endfunction

  // compares every accepted beat, sampled mid-cycle
  always @(negedge clk_i) begin : beat_checker
    int unsigned idx;
    word_t       expected;
    if (rst_ni && stream_valid_o && stream_ready_i) begin
      idx = beats_seen - job_first_beat;
      assert (idx < job_total) else
        abort_run($sformatf("ERR %s: expected %0d beats, actual beat number %0d",
                            test_name, job_total, idx + 1));
      expected = ref_word(idx);
      assert (stream_data_o == expected) else
        abort_run($sformatf("ERR %s: expected %h, actual %h",
                            test_name, expected, stream_data_o));
      beats_seen = beats_seen + 1;
    end
  end

  task automatic preload_bank();
    word_t data;
    for (int i = 0; i < BANK_WORDS; i++) begin
      data = $urandom;
      @(posedge clk_i);
      wr_en_i   <= 1'b1;
      wr_addr_i <= addr_t'(i * 4);
      wr_data_i <= data;
      shadow[i] = data;
    end
    @(posedge clk_i);
    wr_en_i <= 1'b0;
  endtask

  task automatic start_job(input string name, input addr_t base, input int unsigned len,
                           input addr_t stride, input int unsigned cnt);
    test_name      = name;
    job_base       = base;
    job_stride     = stride;
    job_len        = len;
    job_total      = len * cnt;
    job_first_beat = beats_seen;
    @(negedge clk_i);
    check_bit("ready_start before start", 1'b1, ready_start_o);
    @(posedge clk_i);
    start_i       <= 1'b1;
    base_addr_i   <= base;
    line_len_i    <= len_t'(len);
    line_stride_i <= stride;
    line_cnt_i    <= len_t'(cnt);
    @(posedge clk_i);
    start_i <= 1'b0;
  endtask

  task automatic wait_job_done(input bit backpressure, input bit host_writes);
    int unsigned cycles;
    int unsigned idx;
    word_t       data;
    bit          finished;
    cycles   = 0;
    finished = 1'b0;
    while (!finished) begin
      @(negedge clk_i);
      if (done_o) begin
        finished = 1'b1;
      end else begin
        cycles = cycles + 1;
        if (cycles > DONE_TIMEOUT) begin
          abort_run($sformatf("%s: job never finished, no done pulse within %0d cycles",
                              test_name, DONE_TIMEOUT));
        end
        @(posedge clk_i);
        if (backpressure) begin
          stream_ready_i <= ($urandom % 3) != 0;
        end
        if (host_writes && ($urandom % 2) == 0) begin
          idx  = 128 + ($urandom % 128); // upper half, away from the job's words
          data = $urandom;
          wr_en_i   <= 1'b1;
          wr_addr_i <= addr_t'(idx * 4);
          wr_data_i <= data;
          shadow[idx] = data;
        end else begin
          wr_en_i <= 1'b0;
        end
      end
    end
    @(posedge clk_i);
    stream_ready_i <= 1'b1;
    wr_en_i        <= 1'b0;
    @(negedge clk_i);
    check_bit("ready_start after done", 1'b1, ready_start_o);
    assert (beats_seen - job_first_beat == job_total) else
      abort_run($sformatf("ERR %s: expected %0d beats, actual %0d",
                          test_name, job_total, beats_seen - job_first_beat));
    // done must be a single pulse
    repeat (3) begin
      check_bit("done after its pulse", 1'b0, done_o);
      @(negedge clk_i);
    end
  endtask

  initial begin
    void'($urandom(32'h4551ba5d));
    rst_ni         <= 1'b0;
    clear_i        <= 1'b0;
    wr_en_i        <= 1'b0;
    wr_addr_i      <= '0;
    wr_data_i      <= '0;
    start_i        <= 1'b0;
    base_addr_i    <= '0;
    line_len_i     <= '0;
    line_stride_i  <= '0;
    line_cnt_i     <= '0;
    stream_ready_i <= 1'b1;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    test_name = "reset_state";
    @(negedge clk_i);
    check_bit("ready_start", 1'b1, ready_start_o);
    check_bit("stream_valid", 1'b0, stream_valid_o);
    check_bit("done", 1'b0, done_o);

    preload_bank();

    start_job("single_line", 32'h40, 12, 32'h0, 1);
    wait_job_done(1'b0, 1'b0);

    start_job("strided_lines", 32'h100, 5, 32'h24, 6);
    wait_job_done(1'b0, 1'b0);

    start_job("backpressure", 32'h20, 7, 32'h40, 5);
    wait_job_done(1'b1, 1'b0);

    start_job("host_writes", 32'h0, 8, 32'h40, 4); // words stay below 0x200
    wait_job_done(1'b0, 1'b1);

    // abort a long job part way through
    start_job("clear_mid_job", 32'h0, 16, 32'h80, 8);
    repeat (12) @(posedge clk_i);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    @(negedge clk_i);
    check_bit("ready_start after clear", 1'b1, ready_start_o);
    check_bit("stream_valid after clear", 1'b0, stream_valid_o);
    repeat (2) @(posedge clk_i);

    start_job("after_clear", 32'h300, 4, 32'h10, 3);
    wait_job_done(1'b1, 1'b0);

    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- hdl/streamer_source_top.sv
// Streamer source top level

`timescale 1ns/100ps

module streamer_source_top
  import streamer_pkg::*;
#(
  parameter int unsigned BANK_WORDS      = 256,
  parameter int unsigned ADDR_FIFO_DEPTH = 2
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,
  // host preload
  input  logic  wr_en_i,
  input  addr_t wr_addr_i,
  input  word_t wr_data_i,
  // job control
  input  logic  start_i,
  input  addr_t base_addr_i,
  input  len_t  line_len_i,
  input  addr_t line_stride_i,
  input  len_t  line_cnt_i,
  output logic  ready_start_o,
  output logic  done_o,
  // output stream
  output logic  stream_valid_o,
  output word_t stream_data_o,
  input  logic  stream_ready_i
);

  logic  gen_valid;
  addr_t gen_addr;
  logic  gen_ready;
  logic  gen_done;
  logic  gen_en;
  logic  gen_start;

  logic  fifo_valid;
  addr_t fifo_addr;
  logic  fifo_ready;
  logic  fifo_empty;

  logic  mem_req;
  addr_t mem_addr;
  logic  mem_gnt;
  logic  mem_rvalid;
  word_t mem_rdata;

  len_t  word_len;

  assign word_len  = line_len_i * line_cnt_i; // sampled by the core at start
  assign gen_start = start_i & gen_en;        // a start while busy is ignored

  stream_addressgen i_addressgen (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .start_i       ( gen_start     ),
    .base_addr_i   ( base_addr_i   ),
    .line_len_i    ( line_len_i    ),
    .line_stride_i ( line_stride_i ),
    .line_cnt_i    ( line_cnt_i    ),
    .addr_valid_o  ( gen_valid     ),
    .addr_o        ( gen_addr      ),
    .addr_ready_i  ( gen_ready     ),
    .done_o        ( gen_done      )
  );

  stream_fifo #(
    .DEPTH ( ADDR_FIFO_DEPTH )
  ) i_addr_fifo (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .push_valid_i ( gen_valid  ),
    .push_data_i  ( gen_addr   ),
    .push_ready_o ( gen_ready  ),
    .pop_valid_o  ( fifo_valid ),
    .pop_data_o   ( fifo_addr  ),
    .pop_ready_i  ( fifo_ready ),
    .empty_o      ( fifo_empty )
  );

  tcdm_source i_source (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .start_i        ( start_i        ),
    .word_len_i     ( word_len       ),
    .gen_done_i     ( gen_done       ),
    .fifo_empty_i   ( fifo_empty     ),
    .fifo_valid_i   ( fifo_valid     ),
    .fifo_addr_i    ( fifo_addr      ),
    .fifo_ready_o   ( fifo_ready     ),
    .mem_req_o      ( mem_req        ),
    .mem_addr_o     ( mem_addr       ),
    .mem_gnt_i      ( mem_gnt        ),
    .mem_rvalid_i   ( mem_rvalid     ),
    .mem_rdata_i    ( mem_rdata      ),
    .stream_valid_o ( stream_valid_o ),
    .stream_data_o  ( stream_data_o  ),
    .stream_ready_i ( stream_ready_i ),
    .gen_en_o       ( gen_en         ),
    .ready_start_o  ( ready_start_o  ),
    .done_o         ( done_o         )
  );

  tcdm_bank #(
    .BANK_WORDS ( BANK_WORDS )
  ) i_bank (
    .clk_i     ( clk_i      ),
    .rst_ni    ( rst_ni     ),
    .wr_en_i   ( wr_en_i    ),
    .wr_addr_i ( wr_addr_i  ),
    .wr_data_i ( wr_data_i  ),
    .req_i     ( mem_req    ),
    .addr_i    ( mem_addr   ),
    .gnt_o     ( mem_gnt    ),
    .rvalid_o  ( mem_rvalid ),
    .rdata_o   ( mem_rdata  )
  );

endmodule

//--- hdl/tcdm_bank.sv
// Single-port scratchpad bank

`timescale 1ns/100ps

module tcdm_bank
  import streamer_pkg::*;
#(
  parameter int unsigned BANK_WORDS = 256 // power of two, index wraps
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  wr_en_i,
  input  addr_t wr_addr_i,
  input  word_t wr_data_i,
  input  logic  req_i,
  input  addr_t addr_i,
  output logic  gnt_o,
  output logic  rvalid_o,
  output word_t rdata_o
);

  localparam int unsigned IDX_W = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

  word_t            mem_q [BANK_WORDS];
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;
  logic             rvalid_q;
  word_t            rdata_q;

  // word index from the bits above the byte offset
  assign wr_idx = wr_addr_i[IDX_W+1:2];
  assign rd_idx = addr_i[IDX_W+1:2];

  assign gnt_o = req_i & ~wr_en_i; // host write owns the port this cycle

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_idx] <= wr_data_i;
    end
    if (gnt_o) begin
      rdata_q <= mem_q[rd_idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt_o;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

//--- hdl/tcdm_source.sv
// Memory to stream source core

`timescale 1ns/100ps

module tcdm_source
  import streamer_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,
  input  logic  start_i,
  input  len_t  word_len_i,
  input  logic  gen_done_i,
  input  logic  fifo_empty_i,
  input  logic  fifo_valid_i,
  input  addr_t fifo_addr_i,
  output logic  fifo_ready_o,
  output logic  mem_req_o,
  output addr_t mem_addr_o,
  input  logic  mem_gnt_i,
  input  logic  mem_rvalid_i,
  input  word_t mem_rdata_i,
  output logic  stream_valid_o,
  output word_t stream_data_o,
  input  logic  stream_ready_i,
  output logic  gen_en_o,
  output logic  ready_start_o,
  output logic  done_o
);

  streamer_state_t cs, ns;

  len_t  word_len_q;   // job length, sampled at start
  len_t  beat_cnt_q;
  logic  beat_cnt_clr;
  logic  rd_pend_q;    // a granted read is in flight
  logic  rd_valid;
  logic  hold_valid_q;
  word_t hold_data_q;
  logic  busy;

  assign busy = (cs != STREAMER_IDLE);

  // request only when the consumer can take the returning word
  assign mem_req_o    = busy & fifo_valid_i & stream_ready_i;
  assign mem_addr_o   = busy ? fifo_addr_i : '0;
  assign fifo_ready_o = mem_req_o & mem_gnt_i; // pop on grant

  // reads issued before a clear are dropped
  assign rd_valid = mem_rvalid_i & rd_pend_q;

  assign stream_valid_o = rd_valid | hold_valid_q;
  assign stream_data_o  = rd_valid ? mem_rdata_i : hold_data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_pend_q <= 1'b0;
    end else if (clear_i) begin
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= mem_req_o & mem_gnt_i;
    end
  end

  // hold register, catches a word returned while the stream stalls
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (clear_i) begin
      hold_valid_q <= 1'b0;
    end else if (rd_valid && !stream_ready_i) begin
      hold_valid_q <= 1'b1;
    end else if (stream_ready_i) begin
      hold_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_valid) begin
      hold_data_q <= mem_rdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cs == STREAMER_IDLE && start_i) begin
      word_len_q <= word_len_i;
    end
  end

  // beat counter, closes the job
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt_q <= '0;
    end else if (clear_i || beat_cnt_clr) begin
      beat_cnt_q <= '0;
    end else if (stream_valid_o && stream_ready_i) begin
      beat_cnt_q <= beat_cnt_q + len_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs <= STREAMER_IDLE;
    end else if (clear_i) begin
      cs <= STREAMER_IDLE;
    end else begin
      cs <= ns;
    end
  end

  always_comb begin
    ns            = cs;
    ready_start_o = 1'b0;
    done_o        = 1'b0;
    beat_cnt_clr  = 1'b0;
    case (cs)
      STREAMER_IDLE: begin
        ready_start_o = 1'b1;
        if (start_i) ns = STREAMER_WORKING;
      end
      STREAMER_WORKING: begin
        if (gen_done_i) ns = STREAMER_DONE;
      end
      STREAMER_DONE: begin
        // all addresses drained and every word delivered
        if (fifo_empty_i && (beat_cnt_q == word_len_q)) begin
          ns           = STREAMER_IDLE;
          done_o       = 1'b1;
          beat_cnt_clr = 1'b1;
        end
      end
      default: ns = STREAMER_IDLE;
    endcase
  end

  assign gen_en_o = (cs == STREAMER_IDLE); // generator takes a start only when idle

endmodule

//--- hdl/stream_fifo.sv
// Address FIFO

`timescale 1ns/100ps

module stream_fifo
  import streamer_pkg::*;
#(
  parameter int unsigned DEPTH = 2
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,
  input  logic  push_valid_i,
  input  addr_t push_data_i,
  output logic  push_ready_o,
  output logic  pop_valid_o,
  output addr_t pop_data_o,
  input  logic  pop_ready_i,
  output logic  empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  addr_t            mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic push;
  logic pop;

  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign empty_o      = (count_q == '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // both or none, level unchanged
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

//--- hdl/stream_addressgen.sv
// Strided address generator

`timescale 1ns/100ps

module stream_addressgen
  import streamer_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,
  input  logic  start_i,
  input  addr_t base_addr_i,
  input  len_t  line_len_i,
  input  addr_t line_stride_i,
  input  len_t  line_cnt_i,
  output logic  addr_valid_o,
  output addr_t addr_o,
  input  logic  addr_ready_i,
  output logic  done_o
);

  logic  active_q;   // offering addresses
  logic  done_q;
  len_t  word_idx_q; // word within the current line
  len_t  line_idx_q; // current line
  len_t  len_q;
  len_t  cnt_q;
  addr_t stride_q;
  addr_t line_base_q; // running base of the current line, avoids a multiplier
  addr_t addr_q;

  logic step;
  logic last_word;
  logic last_line;
  logic empty_job;

  assign step      = active_q & addr_ready_i;
  assign last_word = (word_idx_q == len_q - len_t'(1));
  assign last_line = (line_idx_q == cnt_q - len_t'(1));
  assign empty_job = (line_len_i == '0) || (line_cnt_i == '0);

  // control state and counters
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q   <= 1'b0;
      done_q     <= 1'b0;
      word_idx_q <= '0;
      line_idx_q <= '0;
    end else if (clear_i) begin
      active_q   <= 1'b0;
      done_q     <= 1'b0;
      word_idx_q <= '0;
      line_idx_q <= '0;
    end else if (start_i) begin
      active_q   <= ~empty_job;
      done_q     <= empty_job; // nothing to walk, finish at once
      word_idx_q <= '0;
      line_idx_q <= '0;
    end else if (step) begin
      if (last_word) begin
        word_idx_q <= '0;
        if (last_line) begin
          active_q <= 1'b0;
          done_q   <= 1'b1;
        end else begin
          line_idx_q <= line_idx_q + len_t'(1);
        end
      end else begin
        word_idx_q <= word_idx_q + len_t'(1);
      end
    end
  end

  // job fields and address registers
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      len_q       <= line_len_i;
      cnt_q       <= line_cnt_i;
      stride_q    <= {line_stride_i[ADDR_WIDTH-1:2], 2'b00};
      line_base_q <= {base_addr_i[ADDR_WIDTH-1:2], 2'b00};
      addr_q      <= {base_addr_i[ADDR_WIDTH-1:2], 2'b00};
    end else if (step) begin
      if (last_word) begin
        // jump to the start of the next line
        line_base_q <= line_base_q + stride_q;
        addr_q      <= line_base_q + stride_q;
      end else begin
        addr_q <= addr_q + WORD_BYTES;
      end
    end
  end

  assign addr_valid_o = active_q;
  assign addr_o       = addr_q;
  assign done_o       = done_q; // held until the next start or clear

endmodule

//--- hdl/streamer_pkg.sv
// Streamer shared definitions

package streamer_pkg;

  // widths that carry a meaning across the streamer
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32; // bank and stream share one word size
  localparam int unsigned LEN_WIDTH  = 16;

  // byte address, word aligned once produced by the generator
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // one data word of the bank and of the output stream
  typedef logic [DATA_WIDTH-1:0] word_t;

  // count of words or lines
  typedef logic [LEN_WIDTH-1:0] len_t;

  // address step between consecutive words of a line
  localparam addr_t WORD_BYTES = addr_t'(DATA_WIDTH / 8);

  // control sequence of the streamer core
  typedef enum logic [1:0] {
    STREAMER_IDLE,
    STREAMER_WORKING,
    STREAMER_DONE
  } streamer_state_t;

endpackage
